//--- fetch_pkg.sv
// shared types and constants for the instruction-fetch subsystem
// every design file refers to these by scoped name, no import
`default_nettype none

package fetch_pkg;

  // word widths with a meaning of their own
  typedef logic [63:0] reg_t;   // register and pc word
  typedef logic [31:0] inst_t;  // one instruction
  typedef logic [1:0]  resp_t;  // bus response code
  typedef logic [1:0]  size_t;  // bus transfer size code

  // bus response codes, AXI-style encoding
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // transfer size, log2 of the byte count
  localparam size_t SIZE_WORD = 2'b10;

  // reset pc and base of the instruction memory
  localparam reg_t PC_START = 64'h0000_0000_8000_0000;

  // opcode field of JAL
  localparam logic [6:0] OPC_JAL = 7'b1101111;

  // fetch controller states
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'b00,  // waiting for the first refresh
    FETCH_ADDR = 2'b01,  // request on the bus
    FETCH_RETN = 2'b10   // result held, finish high
  } fetch_state_e;

  // one fetched instruction with its pc
  typedef struct packed {
    reg_t  pc;
    inst_t inst;
  } fetch_res_t;

endpackage

`default_nettype wire

//--- if_stage.sv
// fetch stage where one refresh pulse starts one fetch over the valid/ready bus
// the returned pc and instruction are held while if_finish is high
// next address priority is exception, then branch/jump, then pc + 4
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  refresh,

  // redirects
  input  wire                  bj_ena,
  input  fetch_pkg::reg_t      bj_pc,
  input  wire                  excp_jmp_ena,
  input  fetch_pkg::reg_t      excp_pc,

  // fetch bus
  output logic                 axi_valid,
  input  wire                  axi_ready,
  output fetch_pkg::reg_t      axi_addr,
  output fetch_pkg::size_t     axi_size,
  input  fetch_pkg::reg_t      axi_rdata,
  input  fetch_pkg::resp_t     axi_resp,

  // result
  output fetch_pkg::fetch_res_t fetch_res,
  output logic                 if_finish,
  output logic                 fetch_err
);

  fetch_pkg::fetch_state_e state;
  fetch_pkg::fetch_state_e next_state;
  fetch_pkg::reg_t         next_addr;
  logic                    handshake;

  assign axi_valid = (state == fetch_pkg::FETCH_ADDR);
  assign axi_size  = fetch_pkg::SIZE_WORD;
  assign if_finish = (state == fetch_pkg::FETCH_RETN);
  assign handshake = axi_valid & axi_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_pkg::FETCH_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;  // hold unless something moves it
    case (state)
      fetch_pkg::FETCH_IDLE: if (refresh) next_state = fetch_pkg::FETCH_ADDR;
      fetch_pkg::FETCH_ADDR: if (handshake) next_state = fetch_pkg::FETCH_RETN;
      fetch_pkg::FETCH_RETN: if (refresh) next_state = fetch_pkg::FETCH_ADDR;
      default:               next_state = fetch_pkg::FETCH_IDLE;
    endcase
  end

  // a jump seen now lands one fetch late as the delay slot
  always_comb begin
    if (excp_jmp_ena) begin
      next_addr = excp_pc;
    end else if (bj_ena) begin
      next_addr = bj_pc;
    end else begin
      next_addr = axi_addr + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      axi_addr     <= fetch_pkg::PC_START;
      fetch_res.pc <= fetch_pkg::PC_START;
    end else if (handshake) begin
      fetch_res.pc <= axi_addr;  // pc of this word
      axi_addr     <= next_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (handshake) begin
      fetch_res.inst <= axi_rdata[31:0];  // low word only
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_err <= 1'b0;
    end else if (handshake && axi_resp != fetch_pkg::RESP_OKAY) begin
      fetch_err <= 1'b1;
    end
  end

  // request holds until the memory accepts it
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    axi_valid && !axi_ready |=> axi_valid && $stable(axi_addr))
    else $error("fetch request dropped or changed before ready");

endmodule

`default_nettype wire

//--- jump_unit.sv
// JAL detection on each fetched instruction
// a found JAL raises bj_ena with its target until the next bus handshake
`timescale 1ns/1ps
`default_nettype none

module jump_unit (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   if_finish,
  input  fetch_pkg::fetch_res_t fetch_res,
  input  wire                   axi_valid,
  input  wire                   axi_ready,
  output logic                  bj_ena,
  output fetch_pkg::reg_t       bj_pc
);

  logic            finish_q;
  logic            finish_rise;
  logic            is_jal;
  logic            handshake;
  fetch_pkg::reg_t j_imm;

  assign finish_rise = if_finish & ~finish_q;  // first cycle of FETCH_RETN
  assign handshake   = axi_valid & axi_ready;
  assign is_jal      = (fetch_res.inst[6:0] == fetch_pkg::OPC_JAL);

  // J-type immediate, bit 0 always zero
  assign j_imm = {{43{fetch_res.inst[31]}},
                  fetch_res.inst[31],
                  fetch_res.inst[19:12],
                  fetch_res.inst[20],
                  fetch_res.inst[30:21],
                  1'b0};

  always_ff @(posedge clk) begin
    if (rst) begin
      finish_q <= 1'b0;
    end else begin
      finish_q <= if_finish;
    end
  end

  // finish and handshake never share a cycle, order only for clarity
  always_ff @(posedge clk) begin
    if (rst) begin
      bj_ena <= 1'b0;
    end else if (handshake) begin
      bj_ena <= 1'b0;  // consumed by the fetch stage
    end else if (finish_rise && is_jal) begin
      bj_ena <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (finish_rise && is_jal) begin
      bj_pc <= fetch_res.pc + j_imm;
    end
  end

  // compressed targets are not supported here
  a_target_aligned: assert property (@(posedge clk) disable iff (rst)
    bj_ena |-> bj_pc[1:0] == 2'b00)
    else $error("jump target not word aligned");

endmodule

`default_nettype wire

//--- imem.sv
// word-addressed instruction memory on the fetch bus
// a load port fills it and each request waits WAIT_CYCLES before ready
// out-of-range addresses or a non-word size return RESP_SLVERR
`timescale 1ns/1ps
`default_nettype none

module imem #(
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_CYCLES = 2
) (
  input  wire               clk,
  input  wire               rst,

  // fetch bus
  input  wire               axi_valid,
  output logic              axi_ready,
  input  fetch_pkg::reg_t   axi_addr,
  input  fetch_pkg::size_t  axi_size,
  output fetch_pkg::reg_t   axi_rdata,
  output fetch_pkg::resp_t  axi_resp,

  // program load
  input  wire               load_en,
  input  fetch_pkg::reg_t   load_idx,
  input  fetch_pkg::inst_t  load_data
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_CYCLES);

  fetch_pkg::inst_t mem [MEM_WORDS];

  logic [CNT_W-1:0] wait_cnt;
  fetch_pkg::reg_t  offset;
  logic             in_range;
  logic             req_ok;

  // byte offset from the memory base
  assign offset   = axi_addr - fetch_pkg::PC_START;
  assign in_range = (axi_addr >= fetch_pkg::PC_START) &&
                    (offset[63:2] < 62'(MEM_WORDS));
  assign req_ok   = in_range && (axi_size == fetch_pkg::SIZE_WORD);

  always_ff @(posedge clk) begin
    if (load_en && load_idx < 64'(MEM_WORDS)) begin
      mem[load_idx[IDX_W-1:0]] <= load_data;
    end
  end

  // counts from the first cycle valid is seen
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (axi_ready) begin
      wait_cnt <= '0;
    end else if (axi_valid) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign axi_ready = axi_valid && (wait_cnt == WAIT_LAST);

  // word zero-extended into the 64-bit data bus
  always_comb begin
    if (req_ok) begin
      axi_rdata = {32'b0, mem[offset[IDX_W+1:2]]};
      axi_resp  = fetch_pkg::RESP_OKAY;
    end else begin
      axi_rdata = '0;
      axi_resp  = fetch_pkg::RESP_SLVERR;
    end
  end

  // a new request sees ready after exactly WAIT_CYCLES cycles
  a_ready_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(axi_valid) |-> ##WAIT_CYCLES axi_ready)
    else $error("ready not WAIT_CYCLES cycles after the request");

  // the fetch stage leaves FETCH_ADDR right after the handshake
  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    axi_ready |=> !axi_ready)
    else $error("ready held longer than one cycle");

endmodule

`default_nettype wire

//--- fetch_top.sv
// top of the fetch subsystem: fetch stage, JAL unit and instruction memory
// memory depth and wait states are set here and passed down
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_CYCLES = 2
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   refresh,
  input  wire                   excp_jmp_ena,
  input  fetch_pkg::reg_t       excp_pc,
  input  wire                   load_en,
  input  fetch_pkg::reg_t       load_idx,
  input  fetch_pkg::inst_t      load_data,
  output fetch_pkg::fetch_res_t fetch_res,
  output logic                  if_finish,
  output logic                  fetch_err
);

  // fetch bus
  logic             axi_valid;
  logic             axi_ready;
  fetch_pkg::reg_t  axi_addr;
  fetch_pkg::size_t axi_size;
  fetch_pkg::reg_t  axi_rdata;
  fetch_pkg::resp_t axi_resp;

  // jump redirect
  logic             bj_ena;
  fetch_pkg::reg_t  bj_pc;

  if_stage if_stage_i (
    .clk          (clk),
    .rst          (rst),
    .refresh      (refresh),
    .bj_ena       (bj_ena),
    .bj_pc        (bj_pc),
    .excp_jmp_ena (excp_jmp_ena),  // straight from the top inputs
    .excp_pc      (excp_pc),
    .axi_valid    (axi_valid),
    .axi_ready    (axi_ready),
    .axi_addr     (axi_addr),
    .axi_size     (axi_size),
    .axi_rdata    (axi_rdata),
    .axi_resp     (axi_resp),
    .fetch_res    (fetch_res),
    .if_finish    (if_finish),
    .fetch_err    (fetch_err)
  );

  jump_unit jump_unit_i (
    .clk       (clk),
    .rst       (rst),
    .if_finish (if_finish),
    .fetch_res (fetch_res),
    .axi_valid (axi_valid),
    .axi_ready (axi_ready),
    .bj_ena    (bj_ena),
    .bj_pc     (bj_pc)
  );

  imem #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) imem_i (
    .clk       (clk),
    .rst       (rst),
    .axi_valid (axi_valid),
    .axi_ready (axi_ready),
    .axi_addr  (axi_addr),
    .axi_size  (axi_size),
    .axi_rdata (axi_rdata),
    .axi_resp  (axi_resp),
    .load_en   (load_en),
    .load_idx  (load_idx),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

//--- fetch_tb.sv
// testbench for fetch_top: loads the program from the stimulus file during reset,
// pulses refresh after each finish with a random gap, and checks every fetched
// pc and instruction, the error flag and the refresh-to-finish latency
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int MEM_WORDS    = 64;
  localparam int WAIT_CYCLES  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int STIM_MAX     = 256;
  localparam int HDR_WORDS    = 2;  // program length, number of expected fetches

  logic                  clk = 1'b1;
  logic                  rst;
  logic                  refresh;
  logic                  excp_jmp_ena;
  fetch_pkg::reg_t       excp_pc;
  logic                  load_en;
  fetch_pkg::reg_t       load_idx;
  fetch_pkg::inst_t      load_data;
  fetch_pkg::fetch_res_t fetch_res;
  logic                  if_finish;
  logic                  fetch_err;

  logic [63:0] stim [STIM_MAX];
  integer      seed = 89;

  fetch_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .refresh      (refresh),
    .excp_jmp_ena (excp_jmp_ena),
    .excp_pc      (excp_pc),
    .load_en      (load_en),
    .load_idx     (load_idx),
    .load_data    (load_data),
    .fetch_res    (fetch_res),
    .if_finish    (if_finish),
    .fetch_err    (fetch_err)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic end_failed(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      end_failed($sformatf("CHECK FAILED %s: expected %h, actual %h",
                           name, expected, actual));
    end
  endtask

  // J-type immediate as the ISA defines it, sign-extended
  function automatic fetch_pkg::reg_t jal_offset(input fetch_pkg::inst_t inst);
    logic [20:0] imm;
    imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return {{43{imm[20]}}, imm};
  endfunction

  function automatic logic in_mem(input fetch_pkg::reg_t pc);
    return (pc >= fetch_pkg::PC_START) &&
           (pc < fetch_pkg::PC_START + 64'(4 * MEM_WORDS));
  endfunction

  initial begin
    int               prog_len;
    int               n_exp;
    int               excp_idx;
    int               exp_base;
    int               word_idx;
    int               gap;
    int               cycles;
    fetch_pkg::reg_t  model_pc;
    fetch_pkg::reg_t  next_pc;
    fetch_pkg::reg_t  jal_tgt;
    fetch_pkg::reg_t  excp_tgt;
    fetch_pkg::reg_t  exp_pc;
    fetch_pkg::inst_t exp_inst;
    logic             jal_prev;
    logic             err_exp;

    rst          = 1'b1;
    refresh      = 1'b0;
    excp_jmp_ena = 1'b0;
    excp_pc      = '0;
    load_en      = 1'b0;
    load_idx     = '0;
    load_data    = '0;

    $readmemh("fetch_stimulus.mem", stim);
    if ($isunknown(stim[0]) || $isunknown(stim[1])) begin
      end_failed("stimulus file is missing or has no header");
    end
    prog_len = int'(stim[0]);
    n_exp    = int'(stim[1]);
    if (prog_len > RESET_CYCLES || prog_len > MEM_WORDS) begin
      end_failed("program is longer than the reset load window or the memory");
    end
    exp_base = HDR_WORDS + prog_len;
    excp_idx = int'(stim[exp_base + 2 * n_exp]);
    excp_tgt = stim[exp_base + 2 * n_exp + 1];

    // one program word per cycle while reset is held
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      load_en   = (i < prog_len);
      load_idx  = 64'(i);
      load_data = stim[HDR_WORDS + i][31:0];
    end
    @(negedge clk);
    rst     = 1'b0;
    load_en = 1'b0;

    model_pc = fetch_pkg::PC_START;
    jal_prev = 1'b0;
    jal_tgt  = '0;
    err_exp  = 1'b0;

    for (int e = 0; e < n_exp; e++) begin
      exp_pc   = stim[exp_base + 2 * e];
      exp_inst = stim[exp_base + 2 * e + 1][31:0];

      // expected entries must follow the fetch rules and the program
      check($sformatf("entry %0d pc by rule", e), model_pc, exp_pc);
      word_idx = int'((exp_pc - fetch_pkg::PC_START) >> 2);
      if (!in_mem(exp_pc)) begin
        check($sformatf("entry %0d inst out of range", e), 64'd0, exp_inst);
      end else if (word_idx < prog_len) begin
        check($sformatf("entry %0d inst in program", e),
              stim[HDR_WORDS + word_idx], exp_inst);
      end else begin
        end_failed($sformatf("entry %0d fetches outside the loaded program", e));
      end
      err_exp = err_exp | !in_mem(exp_pc);  // sticky like the DUT flag

      gap = {$random(seed)} % 4;
      repeat (gap) @(negedge clk);
      @(negedge clk);
      refresh = 1'b1;
      if (e == excp_idx) begin
        excp_jmp_ena = 1'b1;  // overlaps the pending jump
        excp_pc      = excp_tgt;
      end
      cycles = 0;
      do begin
        @(negedge clk);
        refresh = 1'b0;
        cycles++;
      end while (!if_finish);
      excp_jmp_ena = 1'b0;

      check($sformatf("fetch %0d latency", e), WAIT_CYCLES + 2, cycles);
      check($sformatf("fetch %0d pc", e), exp_pc, fetch_res.pc);
      check($sformatf("fetch %0d inst", e), exp_inst, fetch_res.inst);
      check($sformatf("fetch %0d fetch_err", e), err_exp, fetch_err);

      // next pc: exception, then jump one fetch late, else plus 4
      next_pc = model_pc + 64'd4;
      if (jal_prev) next_pc = jal_tgt;
      if (e == excp_idx) next_pc = excp_tgt;
      jal_prev = (exp_inst[6:0] == fetch_pkg::OPC_JAL);
      jal_tgt  = model_pc + jal_offset(exp_inst);
      model_pc = next_pc;
    end

    repeat (2) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

  // worst case per fetch is 4 gap cycles plus the latency
  initial begin
    int limit;
    #1;
    limit = int'(stim[1]) * (WAIT_CYCLES + 8) + RESET_CYCLES + 8;
    repeat (limit) @(posedge clk);
    end_failed($sformatf("watchdog: fetch sequence did not finish within %0d cycles",
                         limit));
  end

endmodule

`default_nettype wire

//--- fetch_stimulus.mem
// fetch stimulus for fetch_tb, all values hex
// header: program length, number of expected fetches; then program words from
// index 0; then one expected fetch per line as pc, instruction; then the index
// of the fetch that sees the exception redirect and its target pc
10 10
// program, four words per line
00108093 0140006F 00208093 00308093
00408093 0100006F 00608093 FF5FF06F
00808093 00908093 0140006F 00B08093
00C08093 00D08093 1C80006F 00F08093
// expected fetches
80000000 00108093
80000004 0140006F // jal +20, forward
80000008 00208093 // delay slot
80000018 00608093
8000001C FF5FF06F // jal -12, backward
80000020 00808093
80000010 00408093
80000014 0100006F // jal +16
80000018 00608093
80000024 00908093
80000028 0140006F // jal +20, beaten by the exception
8000002C 00B08093 // exception redirect pending here
80000034 00D08093
80000038 1C80006F // jal out of the memory
8000003C 00F08093
80000200 00000000 // error response
// exception redirect
0B 80000034

//--- all.f
fetch_pkg.sv
if_stage.sv
jump_unit.sv
imem.sv
fetch_top.sv
fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_subsystem

sources:
  - fetch_pkg.sv
  - if_stage.sv
  - jump_unit.sv
  - imem.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_tb.sv
